//--- source/task_unit_pkg.sv
package task_unit_pkg;

   // Queue sizing
   localparam int LOG_TQ_SIZE = 4;
   localparam int TQ_DEPTH    = 2 ** LOG_TQ_SIZE;
   localparam int TQ_COUNT_W  = LOG_TQ_SIZE + 1;

   // Task payload widths
   localparam int TS_W     = 32;
   localparam int LOCALE_W = 32;
   localparam int ARG_W    = 32;

   localparam int SPILL_SIZE_W = 6;

   // Register bus widths
   localparam int REG_ADDR_W = 8;
   localparam int REG_DATA_W = 32;

   // Configuration after reset
   // Spill size stays a multiple of 8
   localparam int SPILL_THRESHOLD_RST    = 12;
   localparam int SPILL_SIZE_RST         = 8;
   localparam int PRODUCER_THRESHOLD_RST = 4;

   typedef enum logic [3:0] {
      TASK_TYPE_PLAIN    = 4'd0,
      TASK_TYPE_SPLITTER = 4'd15
   } task_type_e;

   typedef struct packed {
      logic [TS_W-1:0]     ts;
      logic [LOCALE_W-1:0] locale;
      task_type_e          ttype;
      logic                producer;
      logic [ARG_W-1:0]    args;
   } task_t;

   typedef logic [TQ_COUNT_W-1:0] tq_count_t;

   typedef enum logic [REG_ADDR_W-1:0] {
      CSR_SPILL_THRESHOLD    = 8'h00,
      CSR_SPILL_SIZE         = 8'h04,
      CSR_PRODUCER_THRESHOLD = 8'h08,
      CSR_N_TASKS            = 8'h10,
      CSR_N_PRODUCER_TASKS   = 8'h14,
      CSR_STAT_ENQ           = 8'h20,
      CSR_STAT_COAL_CHILD    = 8'h24,
      CSR_STAT_DEQ           = 8'h28,
      CSR_STAT_SPLITTER_DEQ  = 8'h2c,
      CSR_STAT_OVERFLOW      = 8'h30
   } csr_addr_e;

   typedef struct packed {
      tq_count_t               spill_threshold;
      logic [SPILL_SIZE_W-1:0] spill_size;
      tq_count_t               producer_threshold;
   } unit_cfg_t;

   // One strobe per completed handshake
   typedef struct packed {
      logic enq;
      logic coal_child;
      logic deq;
      logic splitter_deq;
      logic overflow;
   } unit_events_t;

endpackage

//--- source/task_queue_if.sv
interface task_queue_if
   import task_unit_pkg::*;
();

   logic      wr_en;
   task_t     wr_data;
   logic      rd_en;
   task_t     rd_data;
   logic      full;
   logic      empty;
   tq_count_t count;

   modport queue (
      input  wr_en, wr_data, rd_en,
      output rd_data, full, empty, count
   );

   // Admission side only needs the full flag
   modport writer (
      output wr_en, wr_data,
      input  full
   );

   modport reader (
      output rd_en,
      input  rd_data, empty, count
   );

endinterface

//--- source/task_fifo.sv
module task_fifo
   import task_unit_pkg::*;
(
   input logic         clk,
   input logic         rstn,
   task_queue_if.queue q
);

   task_t                  mem [TQ_DEPTH];
   logic [LOG_TQ_SIZE-1:0] wr_ptr;
   logic [LOG_TQ_SIZE-1:0] rd_ptr;
   tq_count_t              count;

   always_ff @(posedge clk) begin
      if (q.wr_en) begin
         mem[wr_ptr] <= q.wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (q.wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (q.rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({q.wr_en, q.rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head of queue is always on the read port
   assign q.rd_data = mem[rd_ptr];
   assign q.count   = count;
   assign q.empty   = (count == '0);
   assign q.full    = (count == tq_count_t'(TQ_DEPTH));

   no_write_when_full: assert property (
      @(posedge clk) disable iff (!rstn)
      q.wr_en |-> !q.full
   );

   no_read_when_empty: assert property (
      @(posedge clk) disable iff (!rstn)
      q.rd_en |-> !q.empty
   );

endmodule

//--- source/task_admit.sv
module task_admit
   import task_unit_pkg::*;
(
   input  logic          clk,
   input  logic          rstn,

   input  logic          task_enq_valid,
   output logic          task_enq_ready,
   input  task_t         task_enq_data,

   input  logic          coal_child_valid,
   output logic          coal_child_ready,
   input  task_t         coal_child_data,

   input  logic          almost_full,

   task_queue_if.writer  gen_q,
   task_queue_if.writer  prod_q,

   output logic          enq_event,
   output logic          coal_event
);

   task_t wr_task;
   logic  wr_any;

   // Children only wait on a full general queue
   assign coal_child_ready = coal_child_valid & !gen_q.full;
   assign task_enq_ready   = task_enq_valid & !coal_child_ready & !almost_full;

   assign wr_task = coal_child_ready ? coal_child_data : task_enq_data;
   assign wr_any  = coal_child_ready | task_enq_ready;

   // Producer bit picks the queue
   assign gen_q.wr_en    = wr_any & !wr_task.producer;
   assign prod_q.wr_en   = wr_any & wr_task.producer;
   assign gen_q.wr_data  = wr_task;
   assign prod_q.wr_data = wr_task;

   assign enq_event  = task_enq_valid & task_enq_ready;
   assign coal_event = coal_child_valid & coal_child_ready;

   // Enqueue gating needs almost_full up before either queue fills
   full_queue_is_almost_full: assert property (
      @(posedge clk) disable iff (!rstn)
      (gen_q.full || prod_q.full) |-> almost_full
   );

endmodule

//--- source/task_dispatch.sv
module task_dispatch
   import task_unit_pkg::*;
(
   input  logic          clk,
   input  logic          rstn,

   input  unit_cfg_t     cfg,

   task_queue_if.reader  gen_q,
   task_queue_if.reader  prod_q,

   output logic          task_deq_valid,
   input  logic          task_deq_ready,
   output task_t         task_deq_data,

   output logic          splitter_deq_valid,
   input  logic          splitter_deq_ready,
   output task_t         splitter_deq_task,

   output logic          overflow_valid,
   input  logic          overflow_ready,
   output task_t         overflow_data,

   output logic          almost_full,

   output logic          deq_event,
   output logic          splitter_event,
   output logic          overflow_event
);

   logic [SPILL_SIZE_W-1:0] spills_left;
   logic                    spill_prod;
   logic                    spilling;
   logic                    spill_src_empty;
   logic                    deq_producer;
   logic                    prod_is_splitter;

   assign almost_full = (gen_q.count > cfg.spill_threshold) |
                        (prod_q.count > cfg.spill_threshold);

   assign spilling = (spills_left != '0);

   // Burst counter with the source queue fixed at burst start
   always_ff @(posedge clk) begin
      if (!rstn) begin
         spills_left <= '0;
         spill_prod  <= 1'b0;
      end else if (!spilling && almost_full) begin
         spills_left <= cfg.spill_size;
         spill_prod  <= (prod_q.count > cfg.spill_threshold);
      end else if (overflow_valid && overflow_ready) begin
         spills_left <= spills_left - 1'b1;
      end
   end

   assign spill_src_empty = spill_prod ? prod_q.empty : gen_q.empty;
   assign overflow_valid  = spilling & !spill_src_empty;
   assign overflow_data   = spill_prod ? prod_q.rd_data : gen_q.rd_data;

   assign deq_producer     = (gen_q.count < cfg.producer_threshold) & !prod_q.empty;
   assign prod_is_splitter = (prod_q.rd_data.ttype == TASK_TYPE_SPLITTER);

   always_comb begin
      task_deq_valid     = 1'b0;
      splitter_deq_valid = 1'b0;
      task_deq_data      = gen_q.rd_data;
      gen_q.rd_en        = 1'b0;
      prod_q.rd_en       = 1'b0;
      if (!spilling) begin
         if (deq_producer) begin
            if (prod_is_splitter) begin
               splitter_deq_valid = 1'b1;
               prod_q.rd_en       = splitter_deq_ready;
            end else begin
               task_deq_valid = 1'b1;
               task_deq_data  = prod_q.rd_data;
               prod_q.rd_en   = task_deq_ready;
            end
         end else if (!gen_q.empty) begin
            task_deq_valid = 1'b1;
            gen_q.rd_en    = task_deq_ready;
         end
      end else if (overflow_valid && overflow_ready) begin
         // Pop the latched queue on each overflow transfer
         if (spill_prod) begin
            prod_q.rd_en = 1'b1;
         end else begin
            gen_q.rd_en = 1'b1;
         end
      end
   end

   assign splitter_deq_task = prod_q.rd_data;

   assign deq_event      = task_deq_valid & task_deq_ready;
   assign splitter_event = splitter_deq_valid & splitter_deq_ready;
   assign overflow_event = overflow_valid & overflow_ready;

   // A stalled overflow transfer keeps its task
   overflow_held_when_stalled: assert property (
      @(posedge clk) disable iff (!rstn)
      overflow_valid && !overflow_ready |=> overflow_valid && $stable(overflow_data)
   );

endmodule

//--- source/task_unit_csr.sv
module task_unit_csr
   import task_unit_pkg::*;
(
   input  logic                  clk,
   input  logic                  rstn,

   input  logic                  reg_wvalid,
   input  csr_addr_e             reg_waddr,
   input  logic [REG_DATA_W-1:0] reg_wdata,

   input  logic                  reg_arvalid,
   input  csr_addr_e             reg_araddr,
   output logic                  reg_rvalid,
   output logic [REG_DATA_W-1:0] reg_rdata,

   input  tq_count_t             gen_count,
   input  tq_count_t             prod_count,

   input  unit_events_t          events,

   output unit_cfg_t             cfg
);

   logic [REG_DATA_W-1:0] stat_enq;
   logic [REG_DATA_W-1:0] stat_coal_child;
   logic [REG_DATA_W-1:0] stat_deq;
   logic [REG_DATA_W-1:0] stat_splitter_deq;
   logic [REG_DATA_W-1:0] stat_overflow;
   logic [REG_DATA_W-1:0] rd_mux;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cfg.spill_threshold    <= tq_count_t'(SPILL_THRESHOLD_RST);
         cfg.spill_size         <= SPILL_SIZE_W'(SPILL_SIZE_RST);
         cfg.producer_threshold <= tq_count_t'(PRODUCER_THRESHOLD_RST);
      end else if (reg_wvalid) begin
         case (reg_waddr)
            CSR_SPILL_THRESHOLD:    cfg.spill_threshold    <= reg_wdata[TQ_COUNT_W-1:0];
            CSR_SPILL_SIZE:         cfg.spill_size         <= reg_wdata[SPILL_SIZE_W-1:0];
            CSR_PRODUCER_THRESHOLD: cfg.producer_threshold <= reg_wdata[TQ_COUNT_W-1:0];
            default: ;
         endcase
      end
   end

   // Handshake counters
   always_ff @(posedge clk) begin
      if (!rstn) begin
         stat_enq          <= '0;
         stat_coal_child   <= '0;
         stat_deq          <= '0;
         stat_splitter_deq <= '0;
         stat_overflow     <= '0;
      end else begin
         stat_enq          <= stat_enq + REG_DATA_W'(events.enq);
         stat_coal_child   <= stat_coal_child + REG_DATA_W'(events.coal_child);
         stat_deq          <= stat_deq + REG_DATA_W'(events.deq);
         stat_splitter_deq <= stat_splitter_deq + REG_DATA_W'(events.splitter_deq);
         stat_overflow     <= stat_overflow + REG_DATA_W'(events.overflow);
      end
   end

   always_comb begin
      case (reg_araddr)
         CSR_SPILL_THRESHOLD:    rd_mux = REG_DATA_W'(cfg.spill_threshold);
         CSR_SPILL_SIZE:         rd_mux = REG_DATA_W'(cfg.spill_size);
         CSR_PRODUCER_THRESHOLD: rd_mux = REG_DATA_W'(cfg.producer_threshold);
         CSR_N_TASKS:            rd_mux = REG_DATA_W'(gen_count);
         CSR_N_PRODUCER_TASKS:   rd_mux = REG_DATA_W'(prod_count);
         CSR_STAT_ENQ:           rd_mux = stat_enq;
         CSR_STAT_COAL_CHILD:    rd_mux = stat_coal_child;
         CSR_STAT_DEQ:           rd_mux = stat_deq;
         CSR_STAT_SPLITTER_DEQ:  rd_mux = stat_splitter_deq;
         CSR_STAT_OVERFLOW:      rd_mux = stat_overflow;
         default:                rd_mux = '0;
      endcase
   end

   // Read data one cycle after the request
   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

//--- source/task_unit.sv
module task_unit
   import task_unit_pkg::*;
(
   input  logic                  clk,
   input  logic                  rstn,

   input  logic                  task_enq_valid,
   output logic                  task_enq_ready,
   input  task_t                 task_enq_data,

   input  logic                  coal_child_valid,
   output logic                  coal_child_ready,
   input  task_t                 coal_child_data,

   output logic                  task_deq_valid,
   input  logic                  task_deq_ready,
   output task_t                 task_deq_data,

   output logic                  splitter_deq_valid,
   input  logic                  splitter_deq_ready,
   output task_t                 splitter_deq_task,

   output logic                  overflow_valid,
   input  logic                  overflow_ready,
   output task_t                 overflow_data,

   output logic                  full,
   output logic                  almost_full,
   output logic                  empty,

   input  logic                  reg_wvalid,
   input  logic [REG_ADDR_W-1:0] reg_waddr,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   input  logic                  reg_arvalid,
   input  logic [REG_ADDR_W-1:0] reg_araddr,
   output logic                  reg_rvalid,
   output logic [REG_DATA_W-1:0] reg_rdata
);

   task_queue_if gen_q ();
   task_queue_if prod_q ();

   unit_cfg_t    cfg;
   unit_events_t events;

   task_fifo gen_fifo_i (.clk, .rstn, .q(gen_q.queue));
   task_fifo prod_fifo_i (.clk, .rstn, .q(prod_q.queue));

   task_admit task_admit_i (
      .clk, .rstn,
      .task_enq_valid, .task_enq_ready, .task_enq_data,
      .coal_child_valid, .coal_child_ready, .coal_child_data,
      .almost_full,
      .gen_q(gen_q.writer), .prod_q(prod_q.writer),
      .enq_event(events.enq), .coal_event(events.coal_child)
   );

   task_dispatch task_dispatch_i (
      .clk, .rstn, .cfg,
      .gen_q(gen_q.reader), .prod_q(prod_q.reader),
      .task_deq_valid, .task_deq_ready, .task_deq_data,
      .splitter_deq_valid, .splitter_deq_ready, .splitter_deq_task,
      .overflow_valid, .overflow_ready, .overflow_data,
      .almost_full,
      .deq_event(events.deq), .splitter_event(events.splitter_deq),
      .overflow_event(events.overflow)
   );

   task_unit_csr task_unit_csr_i (
      .clk, .rstn,
      .reg_wvalid, .reg_waddr(csr_addr_e'(reg_waddr)), .reg_wdata,
      .reg_arvalid, .reg_araddr(csr_addr_e'(reg_araddr)), .reg_rvalid, .reg_rdata,
      .gen_count(gen_q.count), .prod_count(prod_q.count),
      .events, .cfg
   );

   // Status follows the general queue only
   assign full  = gen_q.full;
   assign empty = gen_q.empty;

endmodule

//--- testbench/task_unit_tb.sv
module task_unit_tb
   import task_unit_pkg::*;
();

   localparam int          CLK_PERIOD = 40;
   localparam int          DRIVE_SKEW = 2;
   localparam logic [31:0] SEED       = 32'h0ebbbfeb;
   localparam string       STIM_FILE  = "testbench/task_unit_stimulus.txt";

   logic                  clk;
   logic                  rstn;
   logic                  task_enq_valid, task_enq_ready;
   task_t                 task_enq_data;
   logic                  coal_child_valid, coal_child_ready;
   task_t                 coal_child_data;
   logic                  task_deq_valid, task_deq_ready;
   task_t                 task_deq_data;
   logic                  splitter_deq_valid, splitter_deq_ready;
   task_t                 splitter_deq_task;
   logic                  overflow_valid, overflow_ready;
   task_t                 overflow_data;
   logic                  full, almost_full, empty;
   logic                  reg_wvalid, reg_arvalid, reg_rvalid;
   logic [REG_ADDR_W-1:0] reg_waddr, reg_araddr;
   logic [REG_DATA_W-1:0] reg_wdata, reg_rdata;

   // Reference model state
   task_t       gq[$];
   task_t       pq[$];
   int          spills_left;
   bit          spill_prod;
   int          spill_th, spill_sz, prod_th;
   int          n_enq, n_coal, n_deq, n_split, n_ovf;
   logic        prev_arvalid;
   logic [7:0]  pend_addr;
   logic [31:0] pend_exp;
   bit          rd_use_file;
   logic [31:0] rd_file_exp;

   int ready_mode_deq, ready_mode_spl, ready_mode_ovf;
   int error_count;
   int cycles;
   int cycle_limit;

   task_unit task_unit_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_run();
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic report_mismatch(input string msg);
      error_count++;
      $display("** Error @%0t: %s", $time, msg);
      stop_run();
   endtask

   task automatic check_task(input task_t act, input task_t exp, input string what);
      if (act !== exp) report_mismatch($sformatf("%s got %h expected %h", what, act, exp));
   endtask

   task automatic check_count(input tq_count_t act, input tq_count_t exp, input string what);
      if (act !== exp) report_mismatch($sformatf("%s got %0d expected %0d", what, act, exp));
   endtask

   task automatic check_reg(input logic [31:0] act, input logic [31:0] exp, input string what);
      if (act !== exp) report_mismatch($sformatf("%s got %h expected %h", what, act, exp));
   endtask

   task automatic check_bit(input logic act, input logic exp, input string what);
      if (act !== exp) report_mismatch($sformatf("%s got %b expected %b", what, act, exp));
   endtask

   function automatic logic [31:0] model_reg(input logic [7:0] addr);
      case (addr)
         CSR_SPILL_THRESHOLD:    return 32'(spill_th);
         CSR_SPILL_SIZE:         return 32'(spill_sz);
         CSR_PRODUCER_THRESHOLD: return 32'(prod_th);
         CSR_N_TASKS:            return 32'(gq.size());
         CSR_N_PRODUCER_TASKS:   return 32'(pq.size());
         CSR_STAT_ENQ:           return 32'(n_enq);
         CSR_STAT_COAL_CHILD:    return 32'(n_coal);
         CSR_STAT_DEQ:           return 32'(n_deq);
         CSR_STAT_SPLITTER_DEQ:  return 32'(n_split);
         CSR_STAT_OVERFLOW:      return 32'(n_ovf);
         default:                return 32'h0;
      endcase
   endfunction

   function automatic task_t make_task(input logic [31:0] ts, input logic [31:0] loc,
                                       input logic [3:0] ty, input logic pr,
                                       input logic [31:0] args);
      task_t t;
      t.ts       = ts;
      t.locale   = loc;
      t.ttype    = task_type_e'(ty);
      t.producer = pr;
      t.args     = args;
      return t;
   endfunction

   function automatic logic ready_value(input int mode);
      if (mode == 2) return 1'($urandom % 2);
      return (mode == 1);
   endfunction

   task automatic apply_readies();
      task_deq_ready     = ready_value(ready_mode_deq);
      splitter_deq_ready = ready_value(ready_mode_spl);
      overflow_ready     = ready_value(ready_mode_ovf);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_SKEW;
      apply_readies();
   endtask

   // Model compares outputs mid-cycle, then steps to the state after the edge
   always @(negedge clk) begin : model_step
      int    gcount, pcount;
      bit    af, spilling, child_rdy, enq_rdy, use_prod;
      bit    exp_deq_v, exp_spl_v, exp_ovf_v;
      task_t t;
      if (rstn) begin
         gcount    = gq.size();
         pcount    = pq.size();
         af        = (gcount > spill_th) || (pcount > spill_th);
         spilling  = (spills_left != 0);
         child_rdy = coal_child_valid && (gcount != TQ_DEPTH);
         enq_rdy   = task_enq_valid && !child_rdy && !af;
         use_prod  = 1'b0;
         exp_deq_v = 1'b0;
         exp_spl_v = 1'b0;
         exp_ovf_v = 1'b0;
         if (spilling) begin
            exp_ovf_v = spill_prod ? (pcount != 0) : (gcount != 0);
         end else if (gcount < prod_th && pcount > 0) begin
            use_prod = 1'b1;
            if (pq[0].ttype == TASK_TYPE_SPLITTER) exp_spl_v = 1'b1;
            else exp_deq_v = 1'b1;
         end else if (gcount > 0) begin
            exp_deq_v = 1'b1;
         end
         check_bit(almost_full, af, "almost_full");
         check_bit(full, gcount == TQ_DEPTH, "full");
         check_bit(empty, gcount == 0, "empty");
         check_bit(coal_child_ready, child_rdy, "coal_child_ready");
         check_bit(task_enq_ready, enq_rdy, "task_enq_ready");
         check_bit(task_deq_valid, exp_deq_v, "task_deq_valid");
         check_bit(splitter_deq_valid, exp_spl_v, "splitter_deq_valid");
         check_bit(overflow_valid, exp_ovf_v, "overflow_valid");
         if (exp_deq_v) check_task(task_deq_data, use_prod ? pq[0] : gq[0], "task_deq_data");
         if (exp_spl_v) check_task(splitter_deq_task, pq[0], "splitter_deq_task");
         if (exp_ovf_v) check_task(overflow_data, spill_prod ? pq[0] : gq[0], "overflow_data");
         check_bit(reg_rvalid, prev_arvalid, "reg_rvalid");
         if (prev_arvalid) begin
            if (pend_addr == CSR_N_TASKS || pend_addr == CSR_N_PRODUCER_TASKS)
               check_count(tq_count_t'(reg_rdata), tq_count_t'(pend_exp), "queue count");
            check_reg(reg_rdata, pend_exp, $sformatf("reg_rdata at %h", pend_addr));
         end
         if (reg_arvalid) begin
            pend_addr = reg_araddr;
            pend_exp  = rd_use_file ? rd_file_exp : model_reg(reg_araddr);
         end
         prev_arvalid = reg_arvalid;

         if (exp_deq_v && task_deq_ready) begin
            n_deq++;
            if (use_prod) void'(pq.pop_front());
            else void'(gq.pop_front());
         end
         if (exp_spl_v && splitter_deq_ready) begin
            n_split++;
            void'(pq.pop_front());
         end
         if (!spilling && af) begin
            spills_left = spill_sz;
            spill_prod  = (pcount > spill_th);
         end else if (exp_ovf_v && overflow_ready) begin
            n_ovf++;
            spills_left--;
            if (spill_prod) void'(pq.pop_front());
            else void'(gq.pop_front());
         end
         if (child_rdy || enq_rdy) begin
            t = child_rdy ? coal_child_data : task_enq_data;
            if (child_rdy) n_coal++;
            else n_enq++;
            if (t.producer) pq.push_back(t);
            else gq.push_back(t);
         end
         if (reg_wvalid) begin
            case (reg_waddr)
               CSR_SPILL_THRESHOLD:    spill_th = int'(reg_wdata[TQ_COUNT_W-1:0]);
               CSR_SPILL_SIZE:         spill_sz = int'(reg_wdata[SPILL_SIZE_W-1:0]);
               CSR_PRODUCER_THRESHOLD: prod_th  = int'(reg_wdata[TQ_COUNT_W-1:0]);
               default: ;
            endcase
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: the run went past %0d cycles", cycle_limit);
         stop_run();
      end
   end

   initial begin : stimulus
      int          fd, n_lines, n, mode_d, mode_s, mode_o;
      string       cmd, line;
      logic [31:0] addr, data, ts, loc, args, ty, pr;
      void'($urandom(SEED));
      rstn = 1'b0;
      task_enq_valid = 1'b0;
      task_enq_data = '0;
      coal_child_valid = 1'b0;
      coal_child_data = '0;
      task_deq_ready = 1'b0;
      splitter_deq_ready = 1'b0;
      overflow_ready = 1'b0;
      reg_wvalid = 1'b0;
      reg_waddr = '0;
      reg_wdata = '0;
      reg_arvalid = 1'b0;
      reg_araddr = '0;
      ready_mode_deq = 0;
      ready_mode_spl = 0;
      ready_mode_ovf = 0;
      spills_left = 0;
      spill_prod = 1'b0;
      spill_th = SPILL_THRESHOLD_RST;
      spill_sz = SPILL_SIZE_RST;
      prod_th = PRODUCER_THRESHOLD_RST;
      prev_arvalid = 1'b0;
      rd_use_file = 1'b0;
      rd_file_exp = '0;
      error_count = 0;
      cycles = 0;
      n_lines = 0;

      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file %s", STIM_FILE);
         stop_run();
      end
      while (!$feof(fd)) begin
         void'($fgets(line, fd));
         n_lines++;
      end
      $fclose(fd);
      cycle_limit = n_lines * 40;

      repeat (4) @(posedge clk);
      #DRIVE_SKEW;
      rstn = 1'b1;

      fd = $fopen(STIM_FILE, "r");
      while ($fscanf(fd, "%s", cmd) == 1) begin
         if (cmd.substr(0, 0) == "#") begin
            void'($fgets(line, fd));
         end else if (cmd == "W") begin
            void'($fscanf(fd, "%h %h", addr, data));
            reg_wvalid = 1'b1;
            reg_waddr  = addr[7:0];
            reg_wdata  = data;
            next_cycle();
            reg_wvalid = 1'b0;
         end else if (cmd == "R" || cmd == "M") begin
            void'($fscanf(fd, "%h", addr));
            rd_use_file = (cmd == "R");
            if (rd_use_file) void'($fscanf(fd, "%h", rd_file_exp));
            reg_arvalid = 1'b1;
            reg_araddr  = addr[7:0];
            next_cycle();
            reg_arvalid = 1'b0;
            next_cycle();
         end else if (cmd == "E" || cmd == "C" || cmd == "B") begin
            void'($fscanf(fd, "%h %h %h %h %h", ts, loc, ty, pr, args));
            task_enq_data    = make_task(ts, loc, ty[3:0], pr[0], args);
            coal_child_data  = task_enq_data;
            task_enq_valid   = (cmd != "C");
            coal_child_valid = (cmd != "E");
            next_cycle();
            task_enq_valid   = 1'b0;
            coal_child_valid = 1'b0;
         end else if (cmd == "G") begin
            // General tasks presented one per cycle
            void'($fscanf(fd, "%d %h", n, args));
            for (int i = 0; i < n; i++) begin
               task_enq_data  = make_task(32'(i), 32'h77, 4'd1, 1'b0, args + 32'(i));
               task_enq_valid = 1'b1;
               next_cycle();
            end
            task_enq_valid = 1'b0;
         end else if (cmd == "Y") begin
            void'($fscanf(fd, "%d %d %d", mode_d, mode_s, mode_o));
            ready_mode_deq = mode_d;
            ready_mode_spl = mode_s;
            ready_mode_ovf = mode_o;
            apply_readies();
         end else if (cmd == "T") begin
            void'($fscanf(fd, "%d", n));
            repeat (n) next_cycle();
         end else begin
            $display("Unknown stimulus command %s", cmd);
            stop_run();
         end
      end
      $fclose(fd);
      next_cycle();

      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- testbench/task_unit_stimulus.txt
# W addr data | R addr expect | M addr (model) | E/C/B ts locale type prod args
# G count args | Y deq spl ovf (0 low, 1 high, 2 random) | T cycles
R 00 0000000c
R 04 00000008
Y 1 1 1
E 1 a 3 0 100
E 2 a 3 0 101
E 3 b 0 0 102
T 3
W 08 00000002
Y 0 0 1
E 10 c 1 0 200
E 11 c 1 0 201
E 12 c 1 0 202
E 20 d f 1 300
E 21 d 2 1 301
R 08 00000002
M 10
M 14
Y 1 1 1
T 8
B 30 e 4 0 400
T 3
W 00 00000003
W 04 00000008
Y 0 1 2
G 12 500
T 40
Y 1 1 1
T 20
M 10
M 20
M 24
M 28
M 2c
M 30

//--- verilog.f
source/task_unit_pkg.sv
source/task_queue_if.sv
source/task_fifo.sv
source/task_admit.sv
source/task_dispatch.sv
source/task_unit_csr.sv
source/task_unit.sv
testbench/task_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= task_unit_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
